//--- decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      stall,
    input  logic      flush,
    input  word_t     if_pc,
    input  word_t     if_instr,
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    output id_ex_t    id_ex
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd;
    word_t      imm;
    ctrl_t      ctrl;

    // ====================
    // Field extraction
    // ====================
    assign opcode = if_instr[6:0];
    assign rd     = if_instr[11:7];
    assign funct3 = if_instr[14:12];
    assign rs1    = if_instr[19:15];
    assign rs2    = if_instr[24:20];
    assign funct7 = if_instr[31:25];

    // Immediate format follows the opcode
    always_comb begin
        case (opcode)
            OP_STORE:  imm = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
            OP_BRANCH: imm = {{19{if_instr[31]}}, if_instr[31], if_instr[7],
                              if_instr[30:25], if_instr[11:8], 1'b0};
            OP_JAL:    imm = {{11{if_instr[31]}}, if_instr[31], if_instr[19:12],
                              if_instr[20], if_instr[30:21], 1'b0};
            OP_LUI:    imm = {if_instr[31:12], 12'b0};
            default:   imm = {{20{if_instr[31]}}, if_instr[31:20]};
        endcase
    end

    // ====================
    // Control decode
    // ====================
    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ALU_ADD;
        ctrl.wb_sel = WB_ALU;
        case (opcode)
            OP_RTYPE, OP_ITYPE: begin
                ctrl.alu_src   = (opcode == OP_ITYPE);
                ctrl.reg_write = 1'b1;
                case (funct3)
                    F3_ADD: begin
                        // SUB only exists in the register form
                        if (opcode == OP_RTYPE && funct7 == F7_SUB) begin
                            ctrl.alu_op = ALU_SUB;
                        end
                    end
                    F3_SLL:  ctrl.alu_op = ALU_SLL;
                    F3_SLT:  ctrl.alu_op = ALU_SLT;
                    F3_XOR:  ctrl.alu_op = ALU_XOR;
                    F3_SRL:  ctrl.alu_op = ALU_SRL;
                    F3_OR:   ctrl.alu_op = ALU_OR;
                    F3_AND:  ctrl.alu_op = ALU_AND;
                    default: ctrl.alu_op = ALU_ADD;
                endcase
            end
            OP_LOAD: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = WB_MEM;
            end
            OP_STORE: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            OP_BRANCH: ctrl.branch = 1'b1;
            OP_JAL: begin
                ctrl.jal       = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = WB_LINK;
            end
            OP_JALR: begin
                ctrl.jalr      = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = WB_LINK;
            end
            OP_LUI: begin
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = WB_IMM;
            end
            default: ctrl.reg_write = 1'b0;
        endcase
        // Writes to x0 are dropped here once for the whole pipe
        if (rd == '0) begin
            ctrl.reg_write = 1'b0;
        end
    end

    // ====================
    // ID/EX register
    // ====================
    always_ff @(posedge clk) begin
        id_ex.pc       <= if_pc;
        id_ex.rs1_data <= rs1_data;
        id_ex.rs2_data <= rs2_data;
        id_ex.rs1      <= rs1;
        id_ex.rs2      <= rs2;
        id_ex.rd       <= rd;
        id_ex.imm      <= imm;
        id_ex.funct3   <= funct3;
        // Bubble for load-use stall or redirect
        if (reset || stall || flush) begin
            id_ex.ctrl <= '0;
        end else begin
            id_ex.ctrl <= ctrl;
        end
    end

endmodule

`default_nettype wire

//--- execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage
    import rv_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  id_ex_t   id_ex,
    input  fwd_sel_t fwd_a,
    input  fwd_sel_t fwd_b,
    input  word_t    wb_result,
    output logic     redirect,
    output word_t    redirect_pc,
    output ex_mem_t  ex_mem
);

    word_t mem_fwd;
    word_t op_a;
    word_t op_b;
    word_t alu_b;
    word_t alu_result;
    logic  taken;

    // ====================
    // Operand forwarding
    // ====================
    // Value of the instruction in MEM, loads excluded by the stall
    always_comb begin
        case (ex_mem.ctrl.wb_sel)
            WB_LINK: mem_fwd = ex_mem.link;
            WB_IMM:  mem_fwd = ex_mem.imm;
            default: mem_fwd = ex_mem.alu_result;
        endcase
    end

    always_comb begin
        case (fwd_a)
            FWD_MEM: op_a = mem_fwd;
            FWD_WB:  op_a = wb_result;
            default: op_a = id_ex.rs1_data;
        endcase
        case (fwd_b)
            FWD_MEM: op_b = mem_fwd;
            FWD_WB:  op_b = wb_result;
            default: op_b = id_ex.rs2_data;
        endcase
    end

    assign alu_b = id_ex.ctrl.alu_src ? id_ex.imm : op_b;

    // ====================
    // ALU
    // ====================
    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_SUB: alu_result = op_a - alu_b;
            ALU_AND: alu_result = op_a & alu_b;
            ALU_OR:  alu_result = op_a | alu_b;
            ALU_XOR: alu_result = op_a ^ alu_b;
            ALU_SLT: alu_result = word_t'($signed(op_a) < $signed(alu_b));
            ALU_SLL: alu_result = op_a << alu_b[4:0];
            ALU_SRL: alu_result = op_a >> alu_b[4:0];
            default: alu_result = op_a + alu_b;
        endcase
    end

    // ====================
    // Branch and jump
    // ====================
    always_comb begin
        case (id_ex.funct3)
            F3_BEQ:  taken = (op_a == op_b);
            F3_BNE:  taken = (op_a != op_b);
            F3_BLT:  taken = ($signed(op_a) < $signed(op_b));
            F3_BGE:  taken = ($signed(op_a) >= $signed(op_b));
            default: taken = 1'b0;
        endcase
    end

    assign redirect = (id_ex.ctrl.branch && taken) || id_ex.ctrl.jal || id_ex.ctrl.jalr;

    // JALR target has bit 0 forced low
    assign redirect_pc = id_ex.ctrl.jalr ? ((op_a + id_ex.imm) & ~word_t'(1))
                                         : (id_ex.pc + id_ex.imm);

    // ====================
    // EX/MEM register
    // ====================
    always_ff @(posedge clk) begin
        ex_mem.alu_result <= alu_result;
        ex_mem.store_data <= op_b;
        ex_mem.rd         <= id_ex.rd;
        ex_mem.link       <= id_ex.pc + word_t'(4);
        ex_mem.imm        <= id_ex.imm;
        if (reset) begin
            ex_mem.ctrl <= '0;
        end else begin
            ex_mem.ctrl <= id_ex.ctrl;
        end
    end

endmodule

`default_nettype wire

//--- fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage
    import rv_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  stall,
    input  logic  flush,
    input  logic  redirect,
    input  word_t redirect_pc,
    input  word_t imem_data,
    output word_t pc,
    output word_t if_pc,
    output word_t if_instr
);

    // ====================
    // Program counter
    // ====================
    // Redirect from EX wins over a load-use stall
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (!stall) begin
            pc <= pc + word_t'(4);
        end
    end

    // ====================
    // IF/ID register
    // ====================
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            if_pc    <= '0;
            if_instr <= NOP_INSTR;
        end else if (!stall) begin
            if_pc    <= pc;
            if_instr <= imem_data;
        end
    end

endmodule

`default_nettype wire

//--- files.f
rv_pkg.sv
fetch_stage.sv
decode_stage.sv
reg_file.sv
hazard_control.sv
execute_stage.sv
mem_wb_stage.sv
rv_core.sv
tb_rv_core.sv

//--- hazard_control.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_control
    import rv_pkg::*;
(
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  id_ex_t    id_ex,
    input  ex_mem_t   ex_mem,
    input  mem_wb_t   mem_wb,
    input  logic      redirect,
    output logic      stall,
    output logic      flush,
    output fwd_sel_t  fwd_a,
    output fwd_sel_t  fwd_b
);

    logic load_in_ex;

    // ====================
    // Load-use and redirect
    // ====================
    // Load result is only ready after MEM, so hold ID for one cycle
    assign load_in_ex = id_ex.ctrl.mem_read && id_ex.ctrl.reg_write;
    assign stall      = load_in_ex && (id_ex.rd == rs1 || id_ex.rd == rs2);

    assign flush = redirect;

    // ====================
    // Forwarding selects
    // ====================
    // Younger producer in MEM takes priority over WB
    always_comb begin
        fwd_a = FWD_NONE;
        if (ex_mem.ctrl.reg_write && ex_mem.rd == id_ex.rs1) begin
            fwd_a = FWD_MEM;
        end else if (mem_wb.reg_write && mem_wb.rd == id_ex.rs1) begin
            fwd_a = FWD_WB;
        end

        fwd_b = FWD_NONE;
        if (ex_mem.ctrl.reg_write && ex_mem.rd == id_ex.rs2) begin
            fwd_b = FWD_MEM;
        end else if (mem_wb.reg_write && mem_wb.rd == id_ex.rs2) begin
            fwd_b = FWD_WB;
        end
    end

endmodule

`default_nettype wire

//--- mem_wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage
    import rv_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  ex_mem_t ex_mem,
    output mem_wb_t mem_wb,
    output retire_t retire
);

    word_t                     dmem [DMEM_WORDS];
    logic [DMEM_ADDR_BITS-1:0] dmem_idx;
    word_t                     load_data;
    word_t                     result;

    // ====================
    // Data memory
    // ====================
    // Word addressed, byte offset bits ignored
    assign dmem_idx  = ex_mem.alu_result[DMEM_ADDR_BITS+1:2];
    assign load_data = dmem[dmem_idx];

    always_ff @(posedge clk) begin
        if (ex_mem.ctrl.mem_write) begin
            dmem[dmem_idx] <= ex_mem.store_data;
        end
    end

    // Result picked here so WB only drives the register file
    always_comb begin
        case (ex_mem.ctrl.wb_sel)
            WB_MEM:  result = load_data;
            WB_LINK: result = ex_mem.link;
            WB_IMM:  result = ex_mem.imm;
            default: result = ex_mem.alu_result;
        endcase
    end

    // ====================
    // MEM/WB register
    // ====================
    always_ff @(posedge clk) begin
        mem_wb.rd     <= ex_mem.rd;
        mem_wb.result <= result;
        if (reset) begin
            mem_wb.reg_write <= 1'b0;
        end else begin
            mem_wb.reg_write <= ex_mem.ctrl.reg_write;
        end
    end

    // Retire shows what the register file is written with
    assign retire.valid = mem_wb.reg_write;
    assign retire.rd    = mem_wb.rd;
    assign retire.data  = mem_wb.result;

endmodule

`default_nettype wire

//--- reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import rv_pkg::*;
(
    input  logic      clk,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  mem_wb_t   wb,
    output word_t     rs1_data,
    output word_t     rs2_data
);

    word_t regs [31:1];

    // reg_write is never set with rd of zero
    always_ff @(posedge clk) begin
        if (wb.reg_write) begin
            regs[wb.rd] <= wb.result;
        end
    end

    // Same-cycle write shows through to the reader in ID
    always_comb begin
        if (rs1 == '0) begin
            rs1_data = '0;
        end else if (wb.reg_write && wb.rd == rs1) begin
            rs1_data = wb.result;
        end else begin
            rs1_data = regs[rs1];
        end

        if (rs2 == '0) begin
            rs2_data = '0;
        end else if (wb.reg_write && wb.rd == rs2) begin
            rs2_data = wb.result;
        end else begin
            rs2_data = regs[rs2];
        end
    end

endmodule

`default_nettype wire

//--- rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core
    import rv_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  word_t   imem_data,
    output word_t   imem_addr,
    output retire_t retire
);

    logic      stall;
    logic      flush;
    logic      redirect;
    word_t     redirect_pc;
    word_t     if_pc;
    word_t     if_instr;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rs1_data;
    word_t     rs2_data;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    mem_wb_t   mem_wb;
    fwd_sel_t  fwd_a;
    fwd_sel_t  fwd_b;

    // ====================
    // Pipeline stages
    // ====================
    fetch_stage u_fetch (
        .clk(clk), .reset(reset), .stall(stall), .flush(flush),
        .redirect(redirect), .redirect_pc(redirect_pc), .imem_data(imem_data),
        .pc(imem_addr), .if_pc(if_pc), .if_instr(if_instr)
    );

    decode_stage u_decode (
        .clk(clk), .reset(reset), .stall(stall), .flush(flush),
        .if_pc(if_pc), .if_instr(if_instr), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .rs1(rs1), .rs2(rs2), .id_ex(id_ex)
    );

    reg_file u_regs (
        .clk(clk), .rs1(rs1), .rs2(rs2), .wb(mem_wb),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    execute_stage u_execute (
        .clk(clk), .reset(reset), .id_ex(id_ex), .fwd_a(fwd_a), .fwd_b(fwd_b),
        .wb_result(mem_wb.result), .redirect(redirect), .redirect_pc(redirect_pc),
        .ex_mem(ex_mem)
    );

    mem_wb_stage u_mem_wb (
        .clk(clk), .reset(reset), .ex_mem(ex_mem), .mem_wb(mem_wb), .retire(retire)
    );

    // Stall, flush and forwarding
    hazard_control u_hazard (
        .rs1(rs1), .rs2(rs2), .id_ex(id_ex), .ex_mem(ex_mem), .mem_wb(mem_wb),
        .redirect(redirect), .stall(stall), .flush(flush), .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

endmodule

`default_nettype wire

//--- rv_core_golden.hex
// Word 0 is the program length, then the program words, then the retire record count
// Each record is two words: rd in bits 31:24, then the expected register value
0000001A
123450B7 // lui  x1, 0x12345
00500113 // addi x2, x0, 5
002081B3 // add  x3, x1, x2
0021D233 // srl  x4, x3, x2
FFF24293 // xori x5, x4, -1
0022A333 // slt  x6, x5, x2
006113B3 // sll  x7, x2, x6
00302423 // sw   x3, 8(x0)
00802403 // lw   x8, 8(x0)
401404B3 // sub  x9, x8, x1 (load-use)
00148013 // addi x0, x9, 1
00049663 // bne  x9, x0, +12 (taken)
00100513 // addi x10, x0, 1 (skipped)
00200513 // addi x10, x0, 2 (skipped)
00048463 // beq  x9, x0, +8 (not taken)
0002C463 // blt  x5, x0, +8 (taken)
00300513 // addi x10, x0, 3 (skipped)
0002D463 // bge  x5, x0, +8 (not taken)
0080056F // jal  x10, +8
00100593 // addi x11, x0, 1 (skipped)
06100593 // addi x11, x0, 0x61
00058667 // jalr x12, 0(x11), target 0x60
00100693 // addi x13, x0, 1 (skipped)
00200693 // addi x13, x0, 2 (skipped)
00C006B3 // add  x13, x0, x12
0000006F // jal  x0, 0
0000000D
01000000
12345000
02000000
00000005
03000000
12345005
04000000
0091A280
05000000
FF6E5D7F
06000000
00000001
07000000
0000000A
08000000
12345005
09000000
00000005
0A000000
0000004C
0B000000
00000061
0C000000
00000058
0D000000
00000058

//--- rv_pkg.sv
`default_nettype none

package rv_pkg;

    // ====================
    // Widths and basic types
    // ====================
    localparam int XLEN           = 32;
    localparam int DMEM_WORDS     = 256;
    localparam int DMEM_ADDR_BITS = 8;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // ADDI x0,x0,0
    localparam word_t NOP_INSTR = 32'h0000_0013;

    // Major opcodes
    localparam logic [6:0] OP_RTYPE  = 7'b0110011;
    localparam logic [6:0] OP_ITYPE  = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;

    // ALU funct3 codes
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRL = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // Branch funct3 codes
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;

    localparam logic [6:0] F7_SUB = 7'b0100000;

    // ====================
    // Enums
    // ====================
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL, ALU_SRL
    } alu_op_t;

    typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwd_sel_t;

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK, WB_IMM} wb_sel_t;

    // ====================
    // Pipeline structs
    // ====================
    typedef struct packed {
        alu_op_t alu_op;
        logic    alu_src;
        logic    mem_read;
        logic    mem_write;
        logic    reg_write;
        logic    branch;
        logic    jal;
        logic    jalr;
        wb_sel_t wb_sel;
    } ctrl_t;

    typedef struct packed {
        word_t      pc;
        word_t      rs1_data;
        word_t      rs2_data;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        reg_addr_t  rd;
        word_t      imm;
        logic [2:0] funct3;
        ctrl_t      ctrl;
    } id_ex_t;

    typedef struct packed {
        word_t     alu_result;
        word_t     store_data;
        reg_addr_t rd;
        word_t     link;
        word_t     imm;
        ctrl_t     ctrl;
    } ex_mem_t;

    typedef struct packed {
        logic      reg_write;
        reg_addr_t rd;
        word_t     result;
    } mem_wb_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } retire_t;

endpackage

`default_nettype wire

//--- tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core
    import rv_pkg::*;
();

    localparam int GOLDEN_WORDS = 256;
    localparam int RESET_CYCLES = 10;
    localparam int QUIET_CYCLES = 20;
    localparam int CLK_HALF     = 50;

    logic    clk;
    logic    reset;
    word_t   imem_data;
    word_t   imem_addr;
    retire_t retire;

    word_t   golden [GOLDEN_WORDS];
    word_t   prog_len;
    word_t   exp_count;
    word_t   rec_base;
    logic    golden_ok;
    logic    loaded;
    logic    started;
    int      seen;
    int      errors;
    int      checks;

    rv_core dut (
        .clk(clk), .reset(reset), .imem_data(imem_data),
        .imem_addr(imem_addr), .retire(retire)
    );

    // Program words start at golden[1] and read as NOP past the end
    assign imem_data = (imem_addr[31:2] < prog_len) ? golden[imem_addr[31:2] + 1] : NOP_INSTR;

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // ====================
    // Helpers
    // ====================
    task automatic check_value(input string name, input word_t actual, input word_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d, retire records seen: %0d of %0d",
                 checks, errors, seen, exp_count);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    // Length word, program, record count, then two words per record
    task automatic load_golden(output logic ok);
        $readmemh("rv_core_golden.hex", golden);
        prog_len = golden[0];
        ok       = 1'b0;
        if (!$isunknown(prog_len) && prog_len > 0 && prog_len < GOLDEN_WORDS - 2) begin
            exp_count = golden[prog_len + 1];
            rec_base  = prog_len + 2;
            if (!$isunknown(exp_count) && exp_count > 0
                && rec_base + 2 * exp_count <= GOLDEN_WORDS) begin
                ok = 1'b1;
            end
        end
    endtask

    task automatic run_program();
        // Nothing retires and the PC stays at zero while in reset
        for (int i = 1; i < RESET_CYCLES; i++) begin
            @(negedge clk);
            check_value("retire.valid", word_t'(retire.valid), '0);
            check_value("imem_addr", imem_addr, '0);
        end
        @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("retire.valid", word_t'(retire.valid), '0);
        check_value("imem_addr", imem_addr, '0);
        // First fetch reaches WB on the fourth edge after reset
        repeat (3) begin
            @(negedge clk);
            check_value("retire.valid", word_t'(retire.valid), '0);
        end
        started = 1'b1;
        while (seen < exp_count) begin
            @(negedge clk);
        end
        // Program parks in a jump to itself, so nothing more may retire
        repeat (QUIET_CYCLES) @(negedge clk);
    endtask

    // ====================
    // Retire monitor
    // ====================
    always @(negedge clk) begin
        if (started && retire.valid === 1'b1) begin
            if (seen < exp_count) begin
                check_value($sformatf("retire.rd (record %0d)", seen),
                            word_t'(retire.rd), golden[rec_base + 2 * seen] >> 24);
                check_value($sformatf("retire.data (record %0d)", seen),
                            retire.data, golden[rec_base + 2 * seen + 1]);
            end else begin
                errors++;
                $display("ERROR at %0t ns: extra retire of x%0d = %h after all %0d records",
                         $time, retire.rd, retire.data, exp_count);
            end
            seen++;
        end else if (started && retire.valid !== 1'b0) begin
            errors++;
            $display("ERROR at %0t ns: retire.valid is unknown", $time);
        end
    end

    // ====================
    // PC alignment
    // ====================
    // Branch and jump offsets are even and JALR clears bit 0
    always @(negedge clk) begin
        if (started) begin
            check_value("imem_addr[0]", word_t'(imem_addr[0]), '0);
        end
    end

    // ====================
    // Main sequence
    // ====================
    initial begin
        reset     = 1'b1;
        started   = 1'b0;
        loaded    = 1'b0;
        seen      = 0;
        errors    = 0;
        checks    = 0;
        exp_count = '0;
        load_golden(golden_ok);
        if (!golden_ok) begin
            errors++;
            $display("ERROR: rv_core_golden.hex is missing or malformed");
            finish_run();
        end else begin
            loaded = 1'b1;
            run_program();
            finish_run();
        end
    end

    // Watchdog allows 20 cycles per expected record plus a margin
    initial begin
        wait (loaded === 1'b1);
        repeat (exp_count * 20 + 200) @(posedge clk);
        errors++;
        $display("ERROR: timeout with %0d of %0d retire records seen, the rest never retired",
                 seen, exp_count);
        finish_run();
    end

endmodule

`default_nettype wire
